/* board_pkg.sv */
/*
 * Shared definitions for the arcade board wrapper
 * Player count, board and game joystick widths
 * Start, coin and pause bit offsets in the board word
 * Default game reset stretch and the common data types
 */
package board_pkg;

    localparam int N_PLAYERS   = 2;   // Player channels
    localparam int BOARD_JOY_W = 16;  // Joystick word from the board
    localparam int JOY_W       = 10;  // Joystick word seen by the game

    // Offsets before the three-button shift
    localparam int START1_BASE = 6;
    localparam int START2_BASE = 7;
    localparam int COIN_BASE   = 8;
    localparam int PAUSE_BASE  = 9;

    localparam int DEF_GAME_RST_LEN = 255;  // Cycles of game reset after a trigger

    typedef logic [BOARD_JOY_W-1:0] board_joy_t;
    typedef logic [JOY_W-1:0]       game_joy_t;

    // Indexed by player for coins, by button for starts
    typedef logic [1:0] pair_t;

    typedef logic [7:0] color8_t;

endpackage

/* player_if.sv */
/*
 * One player's decoded inputs
 * channel modport drives, merge modport reads
 */
`timescale 1ns/1ps

interface player_if;
    import board_pkg::*;

    game_joy_t joy;    // Rotated, still active high
    pair_t     start;  // {start2, start1}
    logic      coin;
    logic      pause;

    modport channel (
        output joy, start, coin, pause
    );

    modport merge (
        input joy, start, coin, pause
    );

endinterface

/* game_reset.sv */
/*
 * Game reset stretcher
 * Triggers: rst, rst_req, downloading, dip_flip change
 * Active-low follower two cycles behind game_rst
 */
`timescale 1ns/1ps

module game_reset #(
    parameter int GAME_RST_LEN = 255
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic dip_flip,
    output logic game_rst,
    output logic game_rst_n
);

    localparam int CNT_W = $clog2(GAME_RST_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(GAME_RST_LEN);

    logic             last_dip_flip;
    logic [CNT_W-1:0] rst_cnt;
    logic             trigger;
    logic             pre_rst_n;

    // A flip of the screen restarts the game
    assign trigger = rst | rst_req | downloading | (dip_flip != last_dip_flip);

    always_ff @(posedge clk_sys) begin
        last_dip_flip <= dip_flip;
    end

    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            rst_cnt  <= '0;  // Restart on every trigger
            game_rst <= 1'b1;
        end else if (rst_cnt != CNT_END) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;  // Saturated, release the game
        end
    end

    // Clears at once, sets two cycles after game_rst drops
    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

endmodule

/* joy_sync.sv */
/*
 * Two-stage synchroniser for the board joystick words
 * One output word per player
 */
`timescale 1ns/1ps

module joy_sync (
    input  logic                  clk_sys,
    input  board_pkg::board_joy_t board_joystick1,
    input  board_pkg::board_joy_t board_joystick2,
    output board_pkg::board_joy_t joy_word [board_pkg::N_PLAYERS]
);
    import board_pkg::*;

    board_joy_t board_word [N_PLAYERS];
    board_joy_t stage1     [N_PLAYERS];

    assign board_word[0] = board_joystick1;
    assign board_word[1] = board_joystick2;

    always_ff @(posedge clk_sys) begin
        for (int p = 0; p < N_PLAYERS; p++) begin
            stage1[p]   <= board_word[p];  // May go metastable
            joy_word[p] <= stage1[p];
        end
    end

endmodule

/* joy_channel.sv */
/*
 * Per-player input decoding
 * Joystick bits with optional vertical-screen rotation
 * Start, coin and pause picked at the three-button offsets
 */
`timescale 1ns/1ps

module joy_channel #(
    parameter int THREE_BUTTONS = 0
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rotate_en,
    input  board_pkg::board_joy_t joy_word,
    player_if.channel             player
);
    import board_pkg::*;

    localparam int START1_BIT = START1_BASE + THREE_BUTTONS;
    localparam int START2_BIT = START2_BASE + THREE_BUTTONS;
    localparam int COIN_BIT   = COIN_BASE + THREE_BUTTONS;
    localparam int PAUSE_BIT  = PAUSE_BASE + THREE_BUTTONS;

    logic [1:0] rot_sync;
    game_joy_t  joy_raw;
    game_joy_t  joy_rot;

    // Same two-cycle sync as the joystick words
    always_ff @(posedge clk_sys) begin
        rot_sync <= {rot_sync[0], rotate_en};
    end

    assign joy_raw = joy_word[JOY_W-1:0];

    always_comb begin
        if (rot_sync[1]) begin
            // Swap directions for a rotated monitor
            joy_rot = {joy_raw[9:4], joy_raw[0], joy_raw[1], joy_raw[3], joy_raw[2]};
        end else begin
            joy_rot = joy_raw;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            player.joy   <= '0;
            player.start <= '0;
            player.coin  <= 1'b0;
            player.pause <= 1'b0;
        end else begin
            player.joy   <= joy_rot;
            player.start <= {joy_word[START2_BIT], joy_word[START1_BIT]};
            player.coin  <= joy_word[COIN_BIT];
            player.pause <= joy_word[PAUSE_BIT];
        end
    end

endmodule

/* input_merge.sv */
/*
 * Combines the player channels into game inputs
 * Polarity inversion, per-player coins, ORed starts
 * Service level delay and pause toggle
 */
`timescale 1ns/1ps

module input_merge #(
    parameter int GAME_INPUTS_ACTIVE_LOW = 1
) (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 service,
    player_if.merge              players [board_pkg::N_PLAYERS],
    output board_pkg::game_joy_t game_joystick1,
    output board_pkg::game_joy_t game_joystick2,
    output board_pkg::pair_t     game_coin,
    output board_pkg::pair_t     game_start,
    output logic                 game_service,
    output logic                 game_pause
);
    import board_pkg::*;

    localparam logic INV = (GAME_INPUTS_ACTIVE_LOW != 0);

    game_joy_t joy_in   [N_PLAYERS];
    logic      coin_in  [N_PLAYERS];
    pair_t     start_in [N_PLAYERS];
    logic      pause_in [N_PLAYERS];

    pair_t      coin_all;
    pair_t      start_any;
    logic       pause_any;
    logic       last_pause;
    logic [2:0] svc_pipe;

    genvar p;
    generate
        for (p = 0; p < N_PLAYERS; p++) begin : g_unpack
            assign joy_in[p]   = players[p].joy;
            assign coin_in[p]  = players[p].coin;
            assign start_in[p] = players[p].start;
            assign pause_in[p] = players[p].pause;
        end
    endgenerate

    always_comb begin
        start_any = '0;
        pause_any = 1'b0;
        for (int i = 0; i < N_PLAYERS; i++) begin
            coin_all[i] = coin_in[i];    // Coin slot per player
            start_any   = start_any | start_in[i];
            pause_any   = pause_any | pause_in[i];
        end
    end

    // Two sync flops plus one to line up with the channel stage
    always_ff @(posedge clk_sys) begin
        svc_pipe <= {svc_pipe[1:0], service};
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= {JOY_W{INV}};
            game_joystick2 <= {JOY_W{INV}};
            game_coin      <= {2{INV}};
            game_start     <= {2{INV}};
            game_service   <= INV;
            game_pause     <= 1'b0;
            last_pause     <= 1'b0;
        end else begin
            game_joystick1 <= {JOY_W{INV}} ^ joy_in[0];
            game_joystick2 <= {JOY_W{INV}} ^ joy_in[1];
            game_coin      <= {2{INV}} ^ coin_all;
            game_start     <= {2{INV}} ^ start_any;
            game_service   <= INV ^ svc_pipe[2];
            last_pause     <= pause_any;
            if (pause_any && !last_pause) begin
                game_pause <= ~game_pause;  // Toggle on rising edge only
            end
        end
    end

endmodule

/* color_expand.sv */
/*
 * Base video colour path
 * Widens COLORW-bit channels to 8 bits on the pixel strobe
 * Registers sync and builds the data-enable from the blanks
 */
`timescale 1ns/1ps

module color_expand #(
    parameter int COLORW = 4
) (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                pxl_cen,
    input  logic [COLORW-1:0]   game_r,
    input  logic [COLORW-1:0]   game_g,
    input  logic [COLORW-1:0]   game_b,
    input  logic                hs,
    input  logic                vs,
    input  logic                lhbl,
    input  logic                lvbl,
    output board_pkg::color8_t  scan_r,
    output board_pkg::color8_t  scan_g,
    output board_pkg::color8_t  scan_b,
    output logic                scan_hs,
    output logic                scan_vs,
    output logic                scan_de
);
    import board_pkg::*;

    // Repeat the channel MSB first until 8 bits are filled
    function automatic color8_t expand(input logic [COLORW-1:0] c);
        color8_t w;
        for (int i = 0; i < 8; i++) begin
            w[7-i] = c[COLORW-1-(i % COLORW)];
        end
        return w;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            scan_r  <= '0;
            scan_g  <= '0;
            scan_b  <= '0;
            scan_hs <= 1'b0;
            scan_vs <= 1'b0;
            scan_de <= 1'b0;
        end else if (pxl_cen) begin
            scan_r  <= expand(game_r);
            scan_g  <= expand(game_g);
            scan_b  <= expand(game_b);
            scan_hs <= hs;
            scan_vs <= vs;
            scan_de <= lhbl & lvbl;  // Visible outside both blanks
        end
    end

endmodule

/* arcade_board.sv */
/*
 * Arcade board wrapper top level
 * Game reset, player input path and base colour path
 */
`timescale 1ns/1ps

module arcade_board #(
    parameter int THREE_BUTTONS          = 0,
    parameter int GAME_INPUTS_ACTIVE_LOW = 1,
    parameter int COLORW                 = 4,
    parameter int GAME_RST_LEN           = board_pkg::DEF_GAME_RST_LEN
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  logic                  dip_flip,
    input  logic                  rotate_en,
    input  logic                  service,
    input  board_pkg::board_joy_t board_joystick1,
    input  board_pkg::board_joy_t board_joystick2,
    input  logic                  pxl_cen,
    input  logic [COLORW-1:0]     game_r,
    input  logic [COLORW-1:0]     game_g,
    input  logic [COLORW-1:0]     game_b,
    input  logic                  hs,
    input  logic                  vs,
    input  logic                  lhbl,
    input  logic                  lvbl,
    output logic                  game_rst,
    output logic                  game_rst_n,
    output board_pkg::game_joy_t  game_joystick1,
    output board_pkg::game_joy_t  game_joystick2,
    output board_pkg::pair_t      game_coin,
    output board_pkg::pair_t      game_start,
    output logic                  game_service,
    output logic                  game_pause,
    output board_pkg::color8_t    scan_r,
    output board_pkg::color8_t    scan_g,
    output board_pkg::color8_t    scan_b,
    output logic                  scan_hs,
    output logic                  scan_vs,
    output logic                  scan_de
);
    import board_pkg::*;

    board_joy_t joy_word [N_PLAYERS];  // Synchronised board words
    player_if   players  [N_PLAYERS] ();

    game_reset #(
        .GAME_RST_LEN (GAME_RST_LEN)
    ) u_game_reset (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .dip_flip    (dip_flip),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

    joy_sync u_joy_sync (
        .clk_sys         (clk_sys),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .joy_word        (joy_word)
    );

    genvar p;
    generate
        for (p = 0; p < N_PLAYERS; p++) begin : g_player
            joy_channel #(
                .THREE_BUTTONS (THREE_BUTTONS)
            ) u_joy_channel (
                .clk_sys   (clk_sys),
                .rst       (rst),
                .rotate_en (rotate_en),
                .joy_word  (joy_word[p]),
                .player    (players[p])
            );
        end
    endgenerate

    input_merge #(
        .GAME_INPUTS_ACTIVE_LOW (GAME_INPUTS_ACTIVE_LOW)
    ) u_input_merge (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .service        (service),
        .players        (players),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .game_pause     (game_pause)
    );

    color_expand #(
        .COLORW (COLORW)
    ) u_color_expand (
        .clk_sys (clk_sys),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .game_r  (game_r),
        .game_g  (game_g),
        .game_b  (game_b),
        .hs      (hs),
        .vs      (vs),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .scan_r  (scan_r),
        .scan_g  (scan_g),
        .scan_b  (scan_b),
        .scan_hs (scan_hs),
        .scan_vs (scan_vs),
        .scan_de (scan_de)
    );

endmodule

/* tb_board_checks.svh */
/*
 * Compare tasks for the arcade board testbench
 * One task per result type: joystick, pair, control bit, colour
 * xorshift generator for the random rows
 */
`ifndef TB_BOARD_CHECKS_SVH
`define TB_BOARD_CHECKS_SVH

task automatic check_joy(input string what, input game_joy_t got, input game_joy_t exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        fail_run();
    end
endtask

task automatic check_pair(input string what, input pair_t got, input pair_t exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        fail_run();
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        fail_run();
    end
endtask

task automatic check_color(input string what, input color8_t got, input color8_t exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        fail_run();
    end
endtask

// 13/17/5 shift triple, full 32-bit period
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

/* tb_arcade_board.sv */
/*
 * Testbench for the arcade board wrapper
 * Reset stretch, joystick table with random rows, pause toggle
 * Colour strobes and game reset triggers, with a watchdog
 */
`timescale 1ns/1ps

module tb_arcade_board;
    import board_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_LEN    = 16;
    localparam int N_TABLE    = 8;
    localparam int N_RAND     = 8;
    localparam int N_ROWS     = N_TABLE + N_RAND;
    localparam int WATCHDOG_CYCLES = N_ROWS * 6 + 200;
    // Three-button offsets
    localparam int START1_BIT = START1_BASE + 1;
    localparam int START2_BIT = START2_BASE + 1;
    localparam int COIN_BIT   = COIN_BASE + 1;
    localparam int PAUSE_BIT  = PAUSE_BASE + 1;
    localparam board_joy_t PAUSE_MASK = board_joy_t'(1 << PAUSE_BIT);

    typedef struct packed {
        board_joy_t b1;
        board_joy_t b2;
        logic       rot;
        logic       svc;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic [3:0] sync;     // {hs, vs, lhbl, lvbl}
        game_joy_t  j1;
        game_joy_t  j2;
        pair_t      coin;
        pair_t      start;
        logic       svc_out;
    } row_t;

    logic clk_sys, rst, rst_req, downloading, dip_flip, rotate_en, service;
    board_joy_t board_joystick1, board_joystick2;
    logic pxl_cen, hs, vs, lhbl, lvbl;
    logic [3:0] game_r, game_g, game_b;
    logic game_rst, game_rst_n, game_service, game_pause;
    game_joy_t game_joystick1, game_joystick2;
    pair_t game_coin, game_start;
    color8_t scan_r, scan_g, scan_b;
    logic scan_hs, scan_vs, scan_de;

    int   error_count = 0;
    row_t rows [N_ROWS];

    `include "tb_board_checks.svh"

    arcade_board #(
        .THREE_BUTTONS          (1),
        .GAME_INPUTS_ACTIVE_LOW (1),
        .COLORW                 (4),
        .GAME_RST_LEN           (RST_LEN)
    ) dut0 (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    task automatic fail_run;
        error_count++;
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    // Expected values straight from the input rules, active low
    function automatic game_joy_t expect_joy(input board_joy_t w, input logic rot);
        game_joy_t j;
        j = w[JOY_W-1:0];
        if (rot) begin
            j[3] = w[0];  // Directions swap for a vertical screen
            j[2] = w[1];
            j[1] = w[3];
            j[0] = w[2];
        end
        return ~j;
    endfunction

    function automatic pair_t expect_coin(input board_joy_t w1, input board_joy_t w2);
        return ~{w2[COIN_BIT], w1[COIN_BIT]};
    endfunction

    function automatic pair_t expect_start(input board_joy_t w1, input board_joy_t w2);
        return ~({w1[START2_BIT], w1[START1_BIT]} | {w2[START2_BIT], w2[START1_BIT]});
    endfunction

    task automatic fill_table;
        logic [31:0] seed;
        board_joy_t  w1;
        board_joy_t  w2;
        rows[0] = '{16'h0000, 16'h0000, 1'b0, 1'b0, 4'h0, 4'h0, 4'h0, 4'b0011,
                    10'h3FF, 10'h3FF, 2'b11, 2'b11, 1'b1};
        rows[1] = '{16'h0001, 16'h0004, 1'b0, 1'b1, 4'h1, 4'h2, 4'h3, 4'b1011,
                    10'h3FE, 10'h3FB, 2'b11, 2'b11, 1'b0};
        rows[2] = '{16'h0001, 16'h0004, 1'b1, 1'b0, 4'h4, 4'h5, 4'h6, 4'b0111,
                    10'h3F7, 10'h3FE, 2'b11, 2'b11, 1'b1};
        rows[3] = '{16'h000A, 16'h0030, 1'b1, 1'b0, 4'h7, 4'h8, 4'h9, 4'b1111,
                    10'h3F9, 10'h3CF, 2'b11, 2'b11, 1'b1};
        rows[4] = '{16'h0280, 16'h0100, 1'b0, 1'b0, 4'hA, 4'hB, 4'hC, 4'b0010,
                    10'h17F, 10'h2FF, 2'b10, 2'b00, 1'b1};  // Coin p1, both starts
        rows[5] = '{16'h0000, 16'h0280, 1'b1, 1'b1, 4'hD, 4'hE, 4'hF, 4'b0001,
                    10'h3FF, 10'h17F, 2'b01, 2'b10, 1'b0};
        rows[6] = '{16'h0180, 16'h0180, 1'b0, 1'b0, 4'hF, 4'h0, 4'h5, 4'b1100,
                    10'h27F, 10'h27F, 2'b11, 2'b00, 1'b1};
        rows[7] = '{16'hF800, 16'hF000, 1'b0, 1'b1, 4'h3, 4'hC, 4'hA, 4'b0011,
                    10'h3FF, 10'h3FF, 2'b11, 2'b11, 1'b0};  // Upper bits ignored
        seed = 32'h378b_8907;
        for (int i = N_TABLE; i < N_ROWS; i++) begin
            seed = xorshift32(seed);
            w1 = seed[15:0] & ~PAUSE_MASK;  // Pause has its own test
            w2 = seed[31:16] & ~PAUSE_MASK;
            seed = xorshift32(seed);
            rows[i].b1      = w1;
            rows[i].b2      = w2;
            rows[i].rot     = seed[0];
            rows[i].svc     = seed[1];
            rows[i].r       = seed[7:4];
            rows[i].g       = seed[11:8];
            rows[i].b       = seed[15:12];
            rows[i].sync    = seed[19:16];
            rows[i].j1      = expect_joy(w1, seed[0]);
            rows[i].j2      = expect_joy(w2, seed[0]);
            rows[i].coin    = expect_coin(w1, w2);
            rows[i].start   = expect_start(w1, w2);
            rows[i].svc_out = ~seed[1];
        end
    endtask

    task automatic set_video(input logic [3:0] r, input logic [3:0] g, input logic [3:0] b,
                             input logic [3:0] sync, input logic cen);
        pxl_cen <= cen;
        game_r  <= r;
        game_g  <= g;
        game_b  <= b;
        hs      <= sync[3];
        vs      <= sync[2];
        lhbl    <= sync[1];
        lvbl    <= sync[0];
    endtask

    // Nibble repeated into the 8-bit channel
    task automatic check_scan(input logic [3:0] r, input logic [3:0] g, input logic [3:0] b,
                              input logic [3:0] sync, input string what);
        check_color({what, " scan_r"}, scan_r, {r, r});
        check_color({what, " scan_g"}, scan_g, {g, g});
        check_color({what, " scan_b"}, scan_b, {b, b});
        check_bit({what, " scan_hs"}, scan_hs, sync[3]);
        check_bit({what, " scan_vs"}, scan_vs, sync[2]);
        check_bit({what, " scan_de"}, scan_de, sync[1] & sync[0]);
    endtask

    // Call right after the edge that drops the trigger
    task automatic check_stretch(input string what);
        for (int n = 1; n <= RST_LEN + 3; n++) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_bit({what, " game_rst"}, game_rst, n <= RST_LEN);
            check_bit({what, " game_rst_n"}, game_rst_n, n >= RST_LEN + 3);
        end
    endtask

    task automatic pulse_trigger(input int which, input string what);
        @(posedge clk_sys);
        case (which)
            0: rst_req <= 1'b1;
            1: downloading <= 1'b1;
            default: dip_flip <= ~dip_flip;
        endcase
        @(negedge clk_sys);
        check_bit({what, " before trigger"}, game_rst, 1'b0);
        @(posedge clk_sys);
        rst_req     <= 1'b0;
        downloading <= 1'b0;
        @(negedge clk_sys);
        check_bit({what, " raised game_rst"}, game_rst, 1'b1);
        check_stretch(what);
    endtask

    task automatic run_table;
        for (int i = 0; i < N_ROWS; i++) begin
            @(posedge clk_sys);
            board_joystick1 <= rows[i].b1;
            board_joystick2 <= rows[i].b2;
            rotate_en       <= rows[i].rot;
            service         <= rows[i].svc;
            set_video(rows[i].r, rows[i].g, rows[i].b, rows[i].sync, 1'b1);
            repeat (4) @(posedge clk_sys);
            @(negedge clk_sys);
            check_joy($sformatf("row %0d game_joystick1", i), game_joystick1, rows[i].j1);
            check_joy($sformatf("row %0d game_joystick2", i), game_joystick2, rows[i].j2);
            check_pair($sformatf("row %0d game_coin", i), game_coin, rows[i].coin);
            check_pair($sformatf("row %0d game_start", i), game_start, rows[i].start);
            check_bit($sformatf("row %0d game_service", i), game_service, rows[i].svc_out);
            check_scan(rows[i].r, rows[i].g, rows[i].b, rows[i].sync,
                       $sformatf("row %0d", i));
        end
    endtask

    task automatic pause_step(input board_joy_t w1, input board_joy_t w2, input logic exp,
                              input string what);
        @(posedge clk_sys);
        board_joystick1 <= w1;
        board_joystick2 <= w2;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit({"game_pause ", what}, game_pause, exp);
    endtask

    task automatic run_strobes;
        @(posedge clk_sys);
        set_video(4'h5, 4'hC, 4'h9, 4'b1011, 1'b1);
        @(posedge clk_sys);
        pxl_cen <= 1'b0;
        @(negedge clk_sys);
        check_scan(4'h5, 4'hC, 4'h9, 4'b1011, "first strobe");
        @(posedge clk_sys);
        set_video(4'hF, 4'h0, 4'hA, 4'b0101, 1'b0);
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_scan(4'h5, 4'hC, 4'h9, 4'b1011, "no strobe");  // Must hold
        @(posedge clk_sys);
        set_video(4'hF, 4'h0, 4'hA, 4'b0101, 1'b1);
        @(posedge clk_sys);
        pxl_cen <= 1'b0;
        @(negedge clk_sys);
        check_scan(4'hF, 4'h0, 4'hA, 4'b0101, "second strobe");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    initial begin
        clk_sys         = 1'b0;
        rst             = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        dip_flip        = 1'b0;
        rotate_en       = 1'b0;
        service         = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        set_video(4'h0, 4'h0, 4'h0, 4'b0000, 1'b0);
        fill_table();

        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("reset game_rst", game_rst, 1'b1);
        check_bit("reset game_rst_n", game_rst_n, 1'b0);
        check_bit("reset game_pause", game_pause, 1'b0);
        check_bit("reset game_service", game_service, 1'b1);
        check_joy("reset game_joystick1", game_joystick1, 10'h3FF);
        check_joy("reset game_joystick2", game_joystick2, 10'h3FF);
        check_pair("reset game_coin", game_coin, 2'b11);
        check_pair("reset game_start", game_start, 2'b11);
        check_scan(4'h0, 4'h0, 4'h0, 4'b0000, "reset");
        @(posedge clk_sys);
        rst <= 1'b0;  // Third reset cycle
        check_stretch("power-on");

        run_table();

        pause_step('0, '0, 1'b0, "idle");
        pause_step(PAUSE_MASK, '0, 1'b1, "player 1 press");
        pause_step('0, '0, 1'b1, "player 1 release");
        pause_step('0, PAUSE_MASK, 1'b0, "player 2 press");
        pause_step(PAUSE_MASK, PAUSE_MASK, 1'b0, "both held");
        pause_step('0, '0, 1'b0, "both release");
        pause_step(PAUSE_MASK, PAUSE_MASK, 1'b1, "both press");

        run_strobes();

        pulse_trigger(0, "rst_req");
        pulse_trigger(1, "downloading");
        pulse_trigger(2, "dip_flip");

        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

/* all.f */
+incdir+.
board_pkg.sv
player_if.sv
game_reset.sv
joy_sync.sv
joy_channel.sv
input_merge.sv
color_expand.sv
arcade_board.sv
tb_arcade_board.sv

/* run_sim.sh */
#!/bin/sh
# Build the arcade board testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module tb_arcade_board &&
./obj_dir/Vtb_arcade_board | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }
